// File: csr_config_capture.sv
// Inputs are sampled once; config_reg keeps the last valid word and a setup request waits for config_ready
`default_nettype none

module csr_config_capture import csr_index_pkg::*; (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              start,
    input  logic              config_ready,
    input  logic              config_valid,
    input  csr_index_config_t config_in,
    input  logic              setup_pulse,
    output logic              start_reg,
    output logic              config_valid_reg,
    output csr_index_config_t config_reg,
    output logic              config_setup
);

    logic config_ready_reg;
    logic setup_pending;

    // ----------------------------------------------------------
    // Input registers
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start_reg        <= 1'b0;
            config_ready_reg <= 1'b0;
            config_valid_reg <= 1'b0;
        end else begin
            start_reg        <= start;
            config_ready_reg <= config_ready;
            config_valid_reg <= config_valid;
        end
    end

    // Payload held until the next valid word
    always_ff @(posedge ap_clk) begin
        if (config_valid) begin
            config_reg <= config_in;
        end
    end

    // ----------------------------------------------------------
    // Setup request
    // ----------------------------------------------------------
    // A request from the sequencer stays pending until the
    // environment reports ready, then goes out as one pulse
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            setup_pending <= 1'b0;
            config_setup  <= 1'b0;
        end else begin
            config_setup <= 1'b0;
            if (setup_pulse) begin
                setup_pending <= 1'b1;
            end else if (setup_pending && config_ready_reg) begin
                setup_pending <= 1'b0;
                config_setup  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: csr_index_generator.sv
// Reset is registered once before use, so outputs settle one cycle after areset rises
`default_nettype none

module csr_index_generator import csr_index_pkg::*; #(
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8
) (
    input  logic              ap_clk,
    input  logic              areset,
    input  logic              start,
    input  logic              config_ready,
    input  logic              config_valid,
    input  csr_index_config_t config_in,
    input  logic              request_ready,
    output logic              config_setup,
    output logic              request_valid,
    output csr_request_t      request_out,
    output logic              done
);

    logic              areset_generator;
    logic              start_reg;
    logic              config_valid_reg;
    csr_index_config_t config_reg;
    logic              setup_pulse;

    csr_push_if push_bus ();

    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    // ----------------------------------------------------------
    // Input side
    // ----------------------------------------------------------
    csr_config_capture u_capture (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .config_ready     (config_ready),
        .config_valid     (config_valid),
        .config_in        (config_in),
        .setup_pulse      (setup_pulse),
        .start_reg        (start_reg),
        .config_valid_reg (config_valid_reg),
        .config_reg       (config_reg),
        .config_setup     (config_setup)
    );

    // ----------------------------------------------------------
    // Index generation
    // ----------------------------------------------------------
    csr_index_sequencer u_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start_reg        (start_reg),
        .config_valid_reg (config_valid_reg),
        .config_reg       (config_reg),
        .setup_pulse      (setup_pulse),
        .push             (push_bus),
        .done             (done)
    );

    // ----------------------------------------------------------
    // Request buffer
    // ----------------------------------------------------------
    csr_request_fifo #(
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) u_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push_bus),
        .request_ready    (request_ready),
        .request_valid    (request_valid),
        .request_out      (request_out)
    );

endmodule

`default_nettype wire

// File: csr_index_pkg.sv
// Shared widths and types; the configuration word is packed MSB first in the field order below
`default_nettype none

package csr_index_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int index_w = 32;
    localparam int addr_w  = 64;
    localparam int shift_w = 5;

    // ----------------------------------------------------------
    // Configuration word, one per start
    // ----------------------------------------------------------
    typedef struct packed {
        logic [addr_w-1:0]  array_pointer;
        logic [index_w-1:0] index_start;
        logic [index_w-1:0] index_end;
        logic [index_w-1:0] stride;
        logic               increment;
        logic               decrement;
        // Set for left shift of the offset, clear for right shift
        logic               shift_left;
        logic [shift_w-1:0] shift_amount;
    } csr_index_config_t;

    // One memory request, 128 bits
    typedef struct packed {
        logic [addr_w-1:0]  base;
        logic [index_w-1:0] offset;
        logic [index_w-1:0] index;
    } csr_request_t;

    // ----------------------------------------------------------
    // Sequencer states
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        gen_reset,
        gen_idle,
        gen_setup_wait,
        gen_setup_trans,
        gen_setup,
        gen_start_trans,
        gen_start,
        gen_busy,
        gen_busy_trans,
        gen_pause_trans,
        gen_pause,
        gen_done_trans,
        gen_done
    } csr_gen_state_t;

endpackage

`default_nettype wire

// File: csr_index_sequencer.sv
// Stride must be nonzero; increment wins when both direction bits are set, neither gives an empty range
`default_nettype none

module csr_index_sequencer import csr_index_pkg::*; (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              start_reg,
    input  logic              config_valid_reg,
    input  csr_index_config_t config_reg,
    output logic              setup_pulse,
    csr_push_if.producer      push,
    output logic              done
);

    csr_gen_state_t current_state;
    csr_gen_state_t next_state;

    logic [index_w-1:0] counter_count;
    logic [index_w-1:0] counter_next;
    logic [index_w-1:0] distance;
    logic               in_range;
    logic               more;
    logic               active;
    logic               issue;
    logic               push_q;
    csr_request_t       request_comb;
    csr_request_t       request_q;

    // ----------------------------------------------------------
    // Range checks
    // ----------------------------------------------------------
    // Distance to index_end decides whether the next step is
    // still inside, so a step past zero or the top never wraps
    always_comb begin
        if (config_reg.increment) begin
            in_range     = counter_count < config_reg.index_end;
            distance     = config_reg.index_end - counter_count;
            counter_next = counter_count + config_reg.stride;
        end else begin
            in_range     = config_reg.decrement && (counter_count > config_reg.index_end);
            distance     = counter_count - config_reg.index_end;
            counter_next = counter_count - config_reg.stride;
        end
        more = distance > config_reg.stride;
    end

    assign issue = (current_state == gen_busy) && active && !push.prog_full;

    // ----------------------------------------------------------
    // State machine
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            current_state <= gen_reset;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            gen_reset: next_state = gen_idle;
            gen_idle: begin
                if (start_reg) begin
                    next_state = gen_setup_trans;
                end
            end
            // One-cycle request, the capture side waits for ready
            gen_setup_trans: next_state = gen_setup_wait;
            gen_setup_wait: begin
                if (config_valid_reg) begin
                    next_state = gen_setup;
                end
            end
            gen_setup:       next_state = gen_start_trans;
            gen_start_trans: next_state = gen_start;
            gen_start:       next_state = gen_busy;
            gen_busy: begin
                if (!active) begin
                    next_state = gen_done_trans;
                end else if (push.prog_full) begin
                    next_state = gen_pause_trans;
                end
            end
            gen_pause_trans: next_state = gen_pause;
            gen_pause: begin
                if (!push.prog_full) begin
                    next_state = gen_busy_trans;
                end
            end
            gen_busy_trans: next_state = gen_busy;
            // Last push has landed by now, only the drain is left
            gen_done_trans: begin
                if (push.empty) begin
                    next_state = gen_done;
                end
            end
            gen_done: begin
                if (start_reg) begin
                    next_state = gen_setup_trans;
                end
            end
            default: next_state = gen_reset;
        endcase
    end

    assign setup_pulse = (current_state == gen_setup_trans);
    assign done        = (current_state == gen_done);

    // ----------------------------------------------------------
    // Control flags
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            active <= 1'b0;
            push_q <= 1'b0;
        end else begin
            push_q <= issue;
            if (current_state == gen_setup) begin
                active <= in_range;
            end else if (issue) begin
                active <= more;
            end
        end
    end

    // ----------------------------------------------------------
    // Counter and request formation
    // ----------------------------------------------------------
    always_comb begin
        request_comb.base  = config_reg.array_pointer;
        request_comb.index = counter_count;
        if (config_reg.shift_left) begin
            request_comb.offset = counter_count << config_reg.shift_amount;
        end else begin
            request_comb.offset = counter_count >> config_reg.shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if ((current_state == gen_setup_wait) && config_valid_reg) begin
            counter_count <= config_reg.index_start;
        end else if (issue) begin
            counter_count <= counter_next;
        end
        request_q <= request_comb;
    end

    assign push.push    = push_q;
    assign push.request = request_q;

endmodule

`default_nettype wire

// File: csr_push_if.sv
// Push side of the request FIFO; every cycle with push high writes one entry, no back-pressure
`default_nettype none

interface csr_push_if import csr_index_pkg::*; ();

    logic         push;
    csr_request_t request;

    // Occupancy flags returned by the FIFO
    logic         prog_full;
    logic         empty;

    // Sequencer side
    modport producer (
        output push,
        output request,
        input  prog_full,
        input  empty
    );

    // FIFO side
    modport consumer (
        input  push,
        input  request,
        output prog_full,
        output empty
    );

endinterface

`default_nettype wire

// File: csr_request_fifo.sv
// Writes are not checked against full; prog_thresh must leave at least two free entries below fifo_depth
`default_nettype none

module csr_request_fifo import csr_index_pkg::*; #(
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8
) (
    input  logic         ap_clk,
    input  logic         areset_generator,
    csr_push_if.consumer push,
    input  logic         request_ready,
    output logic         request_valid,
    output csr_request_t request_out
);

    localparam int ptr_w   = $clog2(fifo_depth);
    localparam int count_w = $clog2(fifo_depth + 1);

    csr_request_t       mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [count_w-1:0] count;
    logic               pop;

    // ----------------------------------------------------------
    // Flags and read side
    // ----------------------------------------------------------
    assign push.empty     = (count == '0);
    assign push.prog_full = (count >= count_w'(prog_thresh));

    // Head entry shown directly, fall-through
    assign request_valid = !push.empty;
    assign request_out   = mem[rd_ptr];
    assign pop           = request_valid && request_ready;

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push.push) begin
            mem[wr_ptr] <= push.request;
        end
    end

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push.push) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: project.f
csr_index_pkg.sv
csr_push_if.sv
csr_config_capture.sv
csr_index_sequencer.sv
csr_request_fifo.sv
csr_index_generator.sv
tb_csr_checker.sv
tb_csr_index_generator.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f project.f \
    --top-module tb_csr_index_generator \
    --Mdir obj_dir \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tb_csr_checker.sv
// Expects only one test armed at a time; any transfer outside an armed test counts as an error
`default_nettype none

module tb_csr_checker import csr_index_pkg::*; (
    input  logic         ap_clk,
    input  logic         request_valid,
    input  logic         request_ready,
    input  csr_request_t request_out,
    input  logic         done,
    output int           error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    string             test_name;
    csr_index_config_t cfg;
    logic              armed;
    logic              done_q;
    longint unsigned   seen;
    longint unsigned   total;

    initial begin
        error_count = 0;
        armed       = 1'b0;
        done_q      = 1'b0;
        seen        = 0;
        total       = 0;
        test_name   = "";
    end

    // ----------------------------------------------------------
    // Reference model of the index rule
    // ----------------------------------------------------------
    function automatic longint unsigned count_for(input csr_index_config_t c);
        longint unsigned first;
        longint unsigned last;
        longint unsigned step;
        first = 64'(c.index_start);
        last  = 64'(c.index_end);
        step  = 64'(c.stride);
        if (c.increment) begin
            return (first < last) ? (last - first + step - 1) / step : 0;
        end
        if (c.decrement) begin
            return (first > last) ? (first - last + step - 1) / step : 0;
        end
        return 0;
    endfunction

    function automatic csr_request_t request_for(input csr_index_config_t c,
                                                 input longint unsigned n);
        csr_request_t    r;
        longint unsigned value;
        longint unsigned factor;
        logic [31:0]     idx;
        if (c.increment) begin
            value = 64'(c.index_start) + n * 64'(c.stride);
        end else begin
            value = 64'(c.index_start) - n * 64'(c.stride);
        end
        idx    = value[31:0];
        // Shift by k is a scale by two to the k
        factor = 1;
        for (int k = 0; k < int'(c.shift_amount); k++) begin
            factor = factor * 2;
        end
        r.base  = c.array_pointer;
        r.index = idx;
        if (c.shift_left) begin
            r.offset = 32'(64'(idx) * factor);
        end else begin
            r.offset = 32'(64'(idx) / factor);
        end
        return r;
    endfunction

    // Called by the testbench as each test starts
    task automatic begin_test(input string name, input csr_index_config_t c);
        test_name = name;
        cfg       = c;
        seen      = 0;
        total     = count_for(c);
        armed     = 1'b1;
    endtask

    // ----------------------------------------------------------
    // Transfer and done monitor
    // ----------------------------------------------------------
    always @(posedge ap_clk) begin
        csr_request_t expected;
        if (request_valid && request_ready) begin
            if (!armed) begin
                $display("A request was transferred while no test was running: %h",
                         request_out);
                error_count = error_count + 1;
            end else if (seen >= total) begin
                $display("Test %s produced an extra request beyond the %0d expected: %h",
                         test_name, total, request_out);
                error_count = error_count + 1;
            end else begin
                expected = request_for(cfg, seen);
                if (request_out !== expected) begin
                    $display("ERROR %s: request %0d expected %h actual %h",
                             test_name, seen, expected, request_out);
                    error_count = error_count + 1;
                end
                seen = seen + 1;
            end
        end
        // All requests must have left the FIFO by the time done rises
        if (armed && done && !done_q) begin
            if (seen != total) begin
                $display("Test %s raised done after %0d of %0d requests, some are missing",
                         test_name, seen, total);
                error_count = error_count + 1;
            end
            armed = 1'b0;
        end
        done_q = done;
    end

endmodule

`default_nettype wire

// File: tb_csr_index_generator.sv
// Runs each table entry through start, config and drain; config_ready is held high after reset
`default_nettype none

module tb_csr_index_generator import csr_index_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          num_cases  = 6;
    localparam int          wait_limit = 5000;
    localparam logic [15:0] lfsr_seed  = 16'd59052;

    logic              ap_clk = 1'b0;
    logic              areset;
    logic              start;
    logic              config_ready;
    logic              config_valid;
    csr_index_config_t config_in;
    logic              request_ready = 1'b0;
    logic              config_setup;
    logic              request_valid;
    csr_request_t      request_out;
    logic              done;

    logic              bp_on;
    logic [15:0]       lfsr = lfsr_seed;
    int                tb_errors;
    int                checker_errors;
    logic              hung;

    // Stimulus table
    string             case_name [num_cases];
    csr_index_config_t case_cfg  [num_cases];
    logic              case_bp   [num_cases];

    always #4 ap_clk = ~ap_clk;

    csr_index_generator dut (
        .ap_clk        (ap_clk),
        .areset        (areset),
        .start         (start),
        .config_ready  (config_ready),
        .config_valid  (config_valid),
        .config_in     (config_in),
        .request_ready (request_ready),
        .config_setup  (config_setup),
        .request_valid (request_valid),
        .request_out   (request_out),
        .done          (done)
    );

    tb_csr_checker u_checker (
        .ap_clk        (ap_clk),
        .request_valid (request_valid),
        .request_ready (request_ready),
        .request_out   (request_out),
        .done          (done),
        .error_count   (checker_errors)
    );

    // ----------------------------------------------------------
    // Back-pressure source
    // ----------------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] v);
        logic [15:0] n;
        n = v >> 1;
        if (v[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    always @(posedge ap_clk) begin
        if (bp_on) begin
            request_ready <= lfsr[0];
            lfsr          <= lfsr_step(lfsr);
        end else begin
            request_ready <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    function automatic csr_index_config_t make_config(
        input logic [63:0] ptr, input logic [31:0] first, input logic [31:0] last,
        input logic [31:0] step, input logic inc, input logic dec,
        input logic shl, input logic [4:0] amount);
        csr_index_config_t c;
        c.array_pointer = ptr;
        c.index_start   = first;
        c.index_end     = last;
        c.stride        = step;
        c.increment     = inc;
        c.decrement     = dec;
        c.shift_left    = shl;
        c.shift_amount  = amount;
        return c;
    endfunction

    task automatic add_case(input int i, input string name, input csr_index_config_t c,
                            input logic bp);
        case_name[i] = name;
        case_cfg[i]  = c;
        case_bp[i]   = bp;
    endtask

    task automatic check_low(input string name, input string what, input logic value);
        if (value !== 1'b0) begin
            $display("ERROR %s: %s expected 0 actual %b", name, what, value);
            tb_errors = tb_errors + 1;
        end
    endtask

    task automatic wait_setup(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(posedge ap_clk);
            cycles = cycles + 1;
        end while (!config_setup && cycles < wait_limit);
        if (!config_setup) begin
            $display("Timeout waiting for config_setup in test %s", name);
            hung = 1'b1;
        end
    endtask

    task automatic wait_done(input string name, input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge ap_clk);
            cycles = cycles + 1;
        end while (done !== level && cycles < wait_limit);
        if (done !== level) begin
            $display("Timeout waiting for done to become %b in test %s", level, name);
            hung = 1'b1;
        end
    endtask

    // One start, one configuration word, then drain until done
    task automatic run_case(input int i);
        bp_on <= case_bp[i];
        @(posedge ap_clk);
        start <= 1'b1;
        u_checker.begin_test(case_name[i], case_cfg[i]);
        @(posedge ap_clk);
        start <= 1'b0;
        wait_done(case_name[i], 1'b0);
        if (!hung) begin
            wait_setup(case_name[i]);
        end
        if (!hung) begin
            config_in    <= case_cfg[i];
            config_valid <= 1'b1;
            @(posedge ap_clk);
            config_valid <= 1'b0;
            wait_done(case_name[i], 1'b1);
        end
        // Gives the checker the cycle with the done edge
        @(posedge ap_clk);
        bp_on <= 1'b0;
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        areset       <= 1'b1;
        start        <= 1'b0;
        config_ready <= 1'b0;
        config_valid <= 1'b0;
        config_in    <= '0;
        bp_on        <= 1'b0;
        tb_errors = 0;
        hung      = 1'b0;

        add_case(0, "inc_stride1_shl",
                 make_config(64'h0000_0040_0000_1000, 5, 17, 1, 1, 0, 1, 3), 1'b0);
        add_case(1, "dec_stride3_shr",
                 make_config(64'h0000_0000_8000_0000, 100, 10, 3, 0, 1, 0, 2), 1'b0);
        add_case(2, "long_backpressure",
                 make_config(64'h0000_1234_5678_0000, 0, 200, 2, 1, 0, 1, 1), 1'b1);
        add_case(3, "empty_increment",
                 make_config(64'h0000_0000_0000_4000, 50, 50, 1, 1, 0, 1, 0), 1'b0);
        add_case(4, "empty_decrement",
                 make_config(64'h0000_0000_0000_8000, 5, 9, 2, 0, 1, 0, 1), 1'b0);
        add_case(5, "dec_backpressure",
                 make_config(64'h00AB_0000_0000_0000, 1000, 0, 7, 0, 1, 1, 4), 1'b1);

        repeat (5) @(posedge ap_clk);
        areset       <= 1'b0;
        config_ready <= 1'b1;
        // Internal reset lags areset by one cycle
        repeat (3) @(posedge ap_clk);
        check_low("after_reset", "request_valid", request_valid);
        check_low("after_reset", "config_setup", config_setup);
        check_low("after_reset", "done", done);

        for (int i = 0; i < num_cases; i++) begin
            if (!hung) begin
                run_case(i);
            end
        end

        $display("Errors: checker %0d, testbench %0d, timeout %0d",
                 checker_errors, tb_errors, hung);
        if (checker_errors == 0 && tb_errors == 0 && !hung) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
